// ==== hw/tag_store_settings.svh ====
// Size macros for the tag store: ways, sets, tag width, RAM latency, index width
`ifndef TAG_STORE_SETTINGS_SVH
`define TAG_STORE_SETTINGS_SVH

// Associativity of the cache
`define TS_WAYS 4

// Number of sets, one tag word per set and way
`define TS_SETS 16

// Stored tag width in bits
`define TS_TAG_W 8

// Read latency of the tag memories in cycles
`define TS_RAM_LAT 1

// Set index width, log2 of TS_SETS
`define TS_IDX_W 4

`endif

// ==== hw/tag_entry_pkg.sv ====
// Tag memory word type and way, index and tag types
package tag_entry_pkg;

`include "tag_store_settings.svh"

  // One bit per way, used as one-hot indicator or as mask
  typedef logic [`TS_WAYS-1:0] way_ind_t;

  // Binary way number
  typedef logic [$clog2(`TS_WAYS)-1:0] way_bin_t;

  // Set index, also the memory address
  typedef logic [`TS_IDX_W-1:0] index_t;

  // Cache line tag
  typedef logic [`TS_TAG_W-1:0] tag_t;

  // Word held in each tag memory location
  typedef struct packed {
    // Line holds data
    logic valid;
    // Line differs from next level
    logic dirty;
    // Stored tag
    tag_t tag;
  } tag_entry_t;

endpackage

// ==== hw/tag_req_pkg.sv ====
// Opcode and controller state enums, request and response structs
package tag_req_pkg;

  // Operation carried by a request
  typedef enum logic [0:0] {
    OP_LOOKUP = 1'b0,
    OP_FLUSH  = 1'b1
  } tag_op_e;

  // Controller states
  typedef enum logic [1:0] {
    // Clearing the tag memories after reset
    ST_INIT = 2'd0,
    // Waiting for a request
    ST_IDLE = 2'd1,
    // Read issued, waiting for memory data
    ST_READ = 2'd2,
    // Read data valid, response held under back-pressure
    ST_RESP = 2'd3
  } ctrl_state_e;

  // Request from the hit/miss side
  typedef struct packed {
    tag_op_e                 op;
    tag_entry_pkg::index_t   index;
    tag_entry_pkg::tag_t     tag;
    // Line is being written, mark it dirty
    logic                    dirty;
    // Ways taking part in a lookup, or the one way to flush
    tag_entry_pkg::way_ind_t way_mask;
  } tag_req_t;

  // Response back to the hit/miss side
  typedef struct packed {
    // One-hot way that was hit, filled or flushed
    tag_entry_pkg::way_ind_t way;
    logic                    hit;
    // Old line must be written back
    logic                    evict;
    tag_entry_pkg::tag_t     evict_tag;
  } tag_res_t;

endpackage

// ==== hw/tag_ram_bank.sv ====
// Tag memories, one per way, with read pipeline and read-valid token
`include "tag_store_settings.svh"

module tag_ram_bank (
  input  logic                                         clk_i,
  input  tag_entry_pkg::way_ind_t                      en_i,
  input  tag_entry_pkg::way_ind_t                      we_i,
  input  tag_entry_pkg::index_t                        idx_i,
  input  tag_entry_pkg::tag_entry_t                    wdata_i,
  output tag_entry_pkg::tag_entry_t [`TS_WAYS-1:0]     rdata_o,
  output logic                                         rd_valid_o
);

  // Read token, one bit per pipeline stage
  logic [`TS_RAM_LAT-1:0] tok_q;

  // Token travels with the data, any way reading starts it
  // Flushed to zero by the init sweep, which only writes
  always_ff @(posedge clk_i) begin
    tok_q[0] <= |(en_i & ~we_i);
    for (int s = 1; s < `TS_RAM_LAT; s++) begin
      tok_q[s] <= tok_q[s-1];
    end
  end

  assign rd_valid_o = tok_q[`TS_RAM_LAT-1];

  for (genvar w = 0; w < `TS_WAYS; w++) begin : gen_way
    tag_entry_pkg::tag_entry_t mem_q [`TS_SETS];
    tag_entry_pkg::tag_entry_t pipe_q [`TS_RAM_LAT];

    // Single port, write has priority over read
    always_ff @(posedge clk_i) begin
      if (en_i[w] && we_i[w]) begin
        mem_q[idx_i] <= wdata_i;
      end
    end

    // Stages only move on a read, so the output holds until the next one
    always_ff @(posedge clk_i) begin
      if (en_i[w] && !we_i[w]) begin
        pipe_q[0] <= mem_q[idx_i];
      end
      for (int s = 1; s < `TS_RAM_LAT; s++) begin
        if (tok_q[s-1]) begin
          pipe_q[s] <= pipe_q[s-1];
        end
      end
    end

    assign rdata_o[w] = pipe_q[`TS_RAM_LAT-1];
  end

endmodule

// ==== hw/tag_compare.sv ====
// Per-way tag compare, valid and dirty vectors, chosen-way entry mux
`include "tag_store_settings.svh"

module tag_compare (
  input  tag_entry_pkg::tag_entry_t [`TS_WAYS-1:0] rdata_i,
  input  tag_entry_pkg::tag_t                      tag_i,
  input  tag_entry_pkg::way_ind_t                  mask_i,
  input  tag_entry_pkg::way_ind_t                  sel_way_i,
  output tag_entry_pkg::way_ind_t                  hit_o,
  output tag_entry_pkg::way_ind_t                  valid_o,
  output tag_entry_pkg::way_ind_t                  dirty_o,
  output tag_entry_pkg::tag_entry_t                sel_entry_o
);

  // Binary form of the chosen way
  tag_entry_pkg::way_bin_t sel_bin;

  for (genvar w = 0; w < `TS_WAYS; w++) begin : gen_cmp
    // Only masked ways with a valid line may hit
    assign hit_o[w]   = mask_i[w] & rdata_i[w].valid & (rdata_i[w].tag == tag_i);
    assign valid_o[w] = rdata_i[w].valid;
    assign dirty_o[w] = rdata_i[w].dirty;
  end

  // One-hot to binary, an empty vector maps to way 0
  always_comb begin
    sel_bin = '0;
    for (int w = 0; w < `TS_WAYS; w++) begin
      if (sel_way_i[w]) begin
        sel_bin = sel_bin | tag_entry_pkg::way_bin_t'(w);
      end
    end
  end

  assign sel_entry_o = rdata_i[sel_bin];

endmodule

// ==== hw/victim_select.sv ====
// Victim way choice, free ways first, then round robin over unlocked ways
`include "tag_store_settings.svh"

module victim_select (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  input  tag_entry_pkg::way_ind_t valid_i,
  input  tag_entry_pkg::way_ind_t lock_i,
  output tag_entry_pkg::way_ind_t victim_o,
  output logic                    evict_o
);

  tag_entry_pkg::way_bin_t ptr_q;
  tag_entry_pkg::way_bin_t rr_bin;
  tag_entry_pkg::way_ind_t free;
  // Set once a way is chosen in the current search
  logic                    found;

  // Unlocked ways without a valid line
  assign free = ~valid_i & ~lock_i;

  always_comb begin
    victim_o = '0;
    evict_o  = 1'b0;
    rr_bin   = ptr_q;
    found    = 1'b0;
    // Lowest free way, nothing to evict
    for (int w = 0; w < `TS_WAYS; w++) begin
      if (!found && free[w]) begin
        victim_o[w] = 1'b1;
        found       = 1'b1;
      end
    end
    // All unlocked ways valid, search from the pointer with wrap
    for (int k = 0; k < `TS_WAYS; k++) begin
      if (!found && !lock_i[(int'(ptr_q) + k) % `TS_WAYS]) begin
        victim_o[(int'(ptr_q) + k) % `TS_WAYS] = 1'b1;
        rr_bin  = tag_entry_pkg::way_bin_t'((int'(ptr_q) + k) % `TS_WAYS);
        evict_o = 1'b1;
        found   = 1'b1;
      end
    end
  end

  // Pointer moves past the way taken by round robin
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (req_i && evict_o) begin
      if (rr_bin == tag_entry_pkg::way_bin_t'(`TS_WAYS - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= rr_bin + 1'b1;
      end
    end
  end

endmodule

// ==== hw/tag_store_ctrl.sv ====
// Tag store FSM: init sweep, lookup, dirty update, miss fill, flush
`include "tag_store_settings.svh"

module tag_store_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  input  tag_req_pkg::tag_req_t     req_i,
  output logic                      req_ready_o,
  output tag_entry_pkg::way_ind_t   ram_en_o,
  output tag_entry_pkg::way_ind_t   ram_we_o,
  output tag_entry_pkg::index_t     ram_idx_o,
  output tag_entry_pkg::tag_entry_t ram_wdata_o,
  input  logic                      rd_valid_i,
  input  tag_entry_pkg::way_ind_t   hit_i,
  input  tag_entry_pkg::way_ind_t   dirty_i,
  output tag_entry_pkg::way_ind_t   sel_way_o,
  input  tag_entry_pkg::tag_entry_t sel_entry_i,
  input  tag_entry_pkg::way_ind_t   victim_i,
  input  logic                      victim_evict_i,
  output logic                      victim_req_o,
  output tag_entry_pkg::tag_t       cur_tag_o,
  output tag_entry_pkg::way_ind_t   cur_mask_o,
  output logic                      res_valid_o,
  output tag_req_pkg::tag_res_t     res_o,
  input  logic                      res_ready_i
);

  tag_req_pkg::ctrl_state_e state_q, state_d;
  tag_req_pkg::tag_req_t    req_q;
  tag_entry_pkg::index_t    init_idx_q;

  logic resp_phase;
  logic res_fire;
  logic take;
  logic is_hit;
  logic is_flush;
  logic dirty_upd;
  logic chain_ok;

  assign is_flush  = (req_q.op == tag_req_pkg::OP_FLUSH);
  assign is_hit    = |hit_i;
  // Hit line not yet dirty but the request writes it
  assign dirty_upd = req_q.dirty & ~|(hit_i & dirty_i);

  // Response is valid once read data arrives and stays until taken
  assign resp_phase  = (state_q == tag_req_pkg::ST_RESP) |
                       ((state_q == tag_req_pkg::ST_READ) & rd_valid_i);
  assign res_valid_o = resp_phase;
  assign res_fire    = resp_phase & res_ready_i;

  // Clean hit frees the memory port, so a new lookup may start now
  assign chain_ok    = res_fire & ~is_flush & is_hit & ~dirty_upd;
  assign req_ready_o = (state_q == tag_req_pkg::ST_IDLE) |
                       (chain_ok & (req_i.op == tag_req_pkg::OP_LOOKUP));
  assign take        = req_valid_i & req_ready_o;

  assign cur_tag_o    = req_q.tag;
  assign cur_mask_o   = req_q.way_mask;
  assign sel_way_o    = is_flush ? req_q.way_mask : (is_hit ? hit_i : victim_i);
  // One pointer step per answered miss
  assign victim_req_o = res_fire & ~is_flush & ~is_hit;

  // Response word
  always_comb begin
    res_o = '0;
    if (is_flush) begin
      res_o.way       = req_q.way_mask;
      res_o.evict     = sel_entry_i.valid & sel_entry_i.dirty;
      res_o.evict_tag = sel_entry_i.tag;
    end else if (is_hit) begin
      res_o.way = hit_i;
      res_o.hit = 1'b1;
    end else begin
      // Empty victim when every way is locked
      res_o.way   = victim_i;
      res_o.evict = victim_evict_i & sel_entry_i.dirty;
      if (victim_evict_i) begin
        res_o.evict_tag = sel_entry_i.tag;
      end
    end
  end

  // Memory control and next state
  always_comb begin
    ram_en_o    = '0;
    ram_we_o    = '0;
    ram_idx_o   = req_q.index;
    ram_wdata_o = '0;
    state_d     = state_q;
    unique case (state_q)
      tag_req_pkg::ST_INIT: begin
        // Zero one set in all ways per cycle
        ram_en_o  = '1;
        ram_we_o  = '1;
        ram_idx_o = init_idx_q;
        if (init_idx_q == tag_entry_pkg::index_t'(`TS_SETS - 1)) begin
          state_d = tag_req_pkg::ST_IDLE;
        end
      end
      tag_req_pkg::ST_IDLE: begin
        if (take) begin
          state_d = tag_req_pkg::ST_READ;
        end
      end
      tag_req_pkg::ST_READ, tag_req_pkg::ST_RESP: begin
        if (resp_phase && !res_ready_i) begin
          // Spill full, hold everything
          state_d = tag_req_pkg::ST_RESP;
        end else if (res_fire) begin
          state_d = tag_req_pkg::ST_IDLE;
          if (is_flush) begin
            // Clear the flushed way
            ram_en_o = req_q.way_mask;
            ram_we_o = req_q.way_mask;
          end else if (!is_hit) begin
            // Fill the victim, nothing written if all ways locked
            ram_en_o    = victim_i;
            ram_we_o    = victim_i;
            ram_wdata_o = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
          end else if (dirty_upd) begin
            ram_en_o    = hit_i;
            ram_we_o    = hit_i;
            ram_wdata_o = '{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
          end else if (take) begin
            state_d = tag_req_pkg::ST_READ;
          end
        end
      end
    endcase
    // New request reads every way of its set
    if (take) begin
      ram_en_o  = '1;
      ram_idx_o = req_i.index;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= tag_req_pkg::ST_INIT;
      init_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == tag_req_pkg::ST_INIT) begin
        init_idx_q <= init_idx_q + 1'b1;
      end
    end
  end

  // Request held for the whole operation
  always_ff @(posedge clk_i) begin
    if (take) begin
      req_q <= req_i;
    end
  end

endmodule

// ==== hw/resp_spill.sv ====
// Two-slot spill register for the response path
module resp_spill (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  tag_req_pkg::tag_res_t data_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output tag_req_pkg::tag_res_t data_o,
  input  logic                  ready_i
);

  // Slot a takes input, slot b catches a stalled output
  tag_req_pkg::tag_res_t a_data_q, b_data_q;
  logic                  a_full_q, b_full_q;
  logic                  a_fill, a_drain;
  logic                  b_fill, b_drain;

  assign a_fill  = valid_i & ready_o;
  // Slot a leaves either to the output or into slot b
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Slot b is older whenever it is full
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  // Depends on register state only
  assign ready_o = ~a_full_q | ~b_full_q;

endmodule

// ==== hw/tag_store_top.sv ====
// Tag store top level: controller, tag memories, compare, victim choice, spill
`include "tag_store_settings.svh"

module tag_store_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  tag_entry_pkg::way_ind_t spm_lock_i,
  input  logic                    req_valid_i,
  input  tag_req_pkg::tag_req_t   req_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output tag_req_pkg::tag_res_t   resp_o,
  input  logic                    resp_ready_i
);

  // Memory request
  tag_entry_pkg::way_ind_t                  ram_en, ram_we;
  tag_entry_pkg::index_t                    ram_idx;
  tag_entry_pkg::tag_entry_t                ram_wdata;
  tag_entry_pkg::tag_entry_t [`TS_WAYS-1:0] ram_rdata;
  logic                                     rd_valid;

  // Compare results
  tag_entry_pkg::way_ind_t   hit, valid, dirty, sel_way, cur_mask;
  tag_entry_pkg::tag_entry_t sel_entry;
  tag_entry_pkg::tag_t       cur_tag;

  // Victim choice
  tag_entry_pkg::way_ind_t victim;
  logic                    victim_evict, victim_req;

  // Controller to spill
  tag_req_pkg::tag_res_t res;
  logic                  res_valid, res_ready;

  tag_store_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .ram_en_o       (ram_en),
    .ram_we_o       (ram_we),
    .ram_idx_o      (ram_idx),
    .ram_wdata_o    (ram_wdata),
    .rd_valid_i     (rd_valid),
    .hit_i          (hit),
    .dirty_i        (dirty),
    .sel_way_o      (sel_way),
    .sel_entry_i    (sel_entry),
    .victim_i       (victim),
    .victim_evict_i (victim_evict),
    .victim_req_o   (victim_req),
    .cur_tag_o      (cur_tag),
    .cur_mask_o     (cur_mask),
    .res_valid_o    (res_valid),
    .res_o          (res),
    .res_ready_i    (res_ready)
  );

  tag_ram_bank u_ram (
    .clk_i      (clk_i),
    .en_i       (ram_en),
    .we_i       (ram_we),
    .idx_i      (ram_idx),
    .wdata_i    (ram_wdata),
    .rdata_o    (ram_rdata),
    .rd_valid_o (rd_valid)
  );

  tag_compare u_cmp (
    .rdata_i     (ram_rdata),
    .tag_i       (cur_tag),
    .mask_i      (cur_mask),
    .sel_way_i   (sel_way),
    .hit_o       (hit),
    .valid_o     (valid),
    .dirty_o     (dirty),
    .sel_entry_o (sel_entry)
  );

  victim_select u_victim (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (victim_req),
    .valid_i  (valid),
    .lock_i   (spm_lock_i),
    .victim_o (victim),
    .evict_o  (victim_evict)
  );

  resp_spill u_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (res_valid),
    .data_i  (res),
    .ready_o (res_ready),
    .valid_o (resp_valid_o),
    .data_o  (resp_o),
    .ready_i (resp_ready_i)
  );

endmodule

// ==== sim/tag_store_properties.sv ====
// Controller checks: single hit way, response held while stalled, no late init writes
`include "tag_store_settings.svh"

module tag_store_properties (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input tag_req_pkg::ctrl_state_e state_i,
  input tag_entry_pkg::way_ind_t  hit_i,
  input tag_entry_pkg::way_ind_t  ram_we_i,
  input logic                     res_valid_i,
  input logic                     res_ready_i,
  input tag_req_pkg::tag_res_t    res_i
);

  // Init sweep cycles seen since reset, stops at the set count
  int unsigned sweep_cnt_q;
  // Number of failed assertions
  int unsigned fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sweep_cnt_q <= 0;
    end else if (state_i == tag_req_pkg::ST_INIT && sweep_cnt_q < `TS_SETS) begin
      sweep_cnt_q <= sweep_cnt_q + 1;
    end
  end

  // A set never holds the same tag twice
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i |-> $onehot0(hit_i))
    else begin
      $error("hit vector %b has more than one way", hit_i);
      fail_cnt++;
    end

  // Stalled response keeps its valid and its contents
  res_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_i)))
    else begin
      $error("response dropped or changed while stalled");
      fail_cnt++;
    end

  // Sweep writes one set per cycle, so it is over after TS_SETS cycles
  no_init_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (sweep_cnt_q == `TS_SETS && state_i == tag_req_pkg::ST_INIT) |-> (ram_we_i == '0))
    else begin
      $error("tag memory written in init state after the sweep");
      fail_cnt++;
    end

endmodule

bind tag_store_ctrl tag_store_properties u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .state_i     (state_q),
  .hit_i       (hit_i),
  .ram_we_i    (ram_we_o),
  .res_valid_i (res_valid_o),
  .res_ready_i (res_ready_i),
  .res_i       (res_o)
);

// ==== sim/tag_store_tb.sv ====
// Tag store testbench: clock, reset, stimulus, reference model and response checks
`include "tag_store_settings.svh"

module tag_store_tb;

  localparam int REQ_TIMEOUT   = 200;
  localparam int INIT_TIMEOUT  = 100;
  localparam int DRAIN_TIMEOUT = 4000;
  localparam logic [15:0] LFSR_SEED = 16'd34145;

  logic                    clk_i;
  logic                    rst_n_i;
  tag_entry_pkg::way_ind_t spm_lock;
  logic                    req_valid;
  tag_req_pkg::tag_req_t   req;
  logic                    req_ready;
  logic                    resp_valid;
  tag_req_pkg::tag_res_t   resp;
  logic                    resp_ready;

  // Model tag array and round-robin pointer
  tag_entry_pkg::tag_entry_t mdl_mem [`TS_SETS][`TS_WAYS];
  int                        mdl_ptr;
  // Expected responses in request order
  tag_req_pkg::tag_res_t     exp_q[$];
  logic [15:0]               stim_lfsr;
  logic [15:0]               bp_lfsr;
  // Random back-pressure on the response port
  logic                      bp_on;
  int                        chk_cnt;
  int                        err_cnt;

  tag_store_top u_tag_store_top (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .spm_lock_i   (spm_lock),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .resp_ready_i (resp_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois LFSR, taps 16 14 13 11, one step per returned bit
  function automatic logic [31:0] rand_bits(inout logic [15:0] st, input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r  = {r[30:0], st[0]};
      st = st[0] ? ((st >> 1) ^ 16'hB400) : (st >> 1);
    end
    return r;
  endfunction

  // Expected response for one request, model state updated as the DUT would
  function automatic tag_req_pkg::tag_res_t model_access(input tag_req_pkg::tag_req_t r,
                                                        input tag_entry_pkg::way_ind_t lock);
    tag_req_pkg::tag_res_t res;
    int way;
    int fw;
    res = '0;
    way = -1;
    if (r.op == tag_req_pkg::OP_FLUSH) begin
      for (int w = 0; w < `TS_WAYS; w++) begin
        if (r.way_mask[w]) begin
          way = w;
        end
      end
      // Stored tag is reported even for an empty line
      res.way       = r.way_mask;
      res.evict     = mdl_mem[r.index][way].valid & mdl_mem[r.index][way].dirty;
      res.evict_tag = mdl_mem[r.index][way].tag;
      mdl_mem[r.index][way] = '0;
      return res;
    end
    for (int w = 0; w < `TS_WAYS; w++) begin
      if (way < 0 && r.way_mask[w] && mdl_mem[r.index][w].valid &&
          mdl_mem[r.index][w].tag == r.tag) begin
        way = w;
      end
    end
    if (way >= 0) begin
      res.way[way] = 1'b1;
      res.hit      = 1'b1;
      if (r.dirty) begin
        mdl_mem[r.index][way].dirty = 1'b1;
      end
      return res;
    end
    // Miss takes the lowest empty unlocked way first
    for (int w = 0; w < `TS_WAYS; w++) begin
      if (way < 0 && !lock[w] && !mdl_mem[r.index][w].valid) begin
        way = w;
      end
    end
    if (way < 0) begin
      for (int k = 0; k < `TS_WAYS; k++) begin
        fw = (mdl_ptr + k) % `TS_WAYS;
        if (way < 0 && !lock[fw]) begin
          way = fw;
        end
      end
      if (way >= 0) begin
        res.evict     = mdl_mem[r.index][way].dirty;
        res.evict_tag = mdl_mem[r.index][way].tag;
        mdl_ptr       = (way + 1) % `TS_WAYS;
      end
    end
    // No way at all when everything is locked
    if (way >= 0) begin
      res.way[way]          = 1'b1;
      mdl_mem[r.index][way] = '{valid: 1'b1, dirty: r.dirty, tag: r.tag};
    end
    return res;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    chk_cnt++;
    assert (got == want) else begin
      $display("error: %s got 0x%0h expected 0x%0h", name, got, want);
      err_cnt++;
    end
  endtask

  // Present one request and hold it until the DUT takes it
  task automatic send_req(input tag_req_pkg::tag_req_t r);
    int cycles;
    cycles = 0;
    exp_q.push_back(model_access(r, spm_lock));
    req       = r;
    req_valid = 1'b1;
    @(negedge clk_i);
    while (!req_ready && cycles < REQ_TIMEOUT) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!req_ready) begin
      $display("request for set %0d was never accepted", r.index);
      err_cnt++;
    end
    @(posedge clk_i);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic lookup(input int idx, input int tg, input logic dirty);
    tag_req_pkg::tag_req_t r;
    r.op       = tag_req_pkg::OP_LOOKUP;
    r.index    = tag_entry_pkg::index_t'(idx);
    r.tag      = tag_entry_pkg::tag_t'(tg);
    r.dirty    = dirty;
    r.way_mask = '1;
    send_req(r);
  endtask

  task automatic flush(input int idx, input int way);
    tag_req_pkg::tag_req_t r;
    r.op       = tag_req_pkg::OP_FLUSH;
    r.index    = tag_entry_pkg::index_t'(idx);
    r.tag      = '0;
    r.dirty    = 1'b0;
    r.way_mask = tag_entry_pkg::way_ind_t'(1 << way);
    send_req(r);
  endtask

  // Wait until every expected response is seen, then report the test
  task automatic finish_test(input string name, input int err_before);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d responses never arrived in test %s", exp_q.size(), name);
      err_cnt++;
      exp_q.delete();
    end
    $display("test %s finished with %0d errors", name, err_cnt - err_before);
  endtask

  // Response ready, random only while back-pressure is on
  initial begin : ready_proc
    resp_ready = 1'b0;
    bp_lfsr    = LFSR_SEED;
    forever begin
      @(posedge clk_i);
      #1;
      resp_ready = bp_on ? (rand_bits(bp_lfsr, 2) != 0) : 1'b1;
    end
  end

  // Compare each accepted response with the oldest expected one
  initial begin : compare_proc
    tag_req_pkg::tag_res_t want;
    forever begin
      @(negedge clk_i);
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("response 0x%0h arrived with no request outstanding", resp);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          check_field("resp_o.way", 32'(resp.way), 32'(want.way));
          check_field("resp_o.hit", 32'(resp.hit), 32'(want.hit));
          check_field("resp_o.evict", 32'(resp.evict), 32'(want.evict));
          check_field("resp_o.evict_tag", 32'(resp.evict_tag), 32'(want.evict_tag));
        end
      end
    end
  end

  initial begin : main_proc
    int   err_before;
    int   cycles;
    int   idx;
    int   tg;
    int   way;
    int   op_sel;
    logic d;
    req_valid = 1'b0;
    req       = '0;
    spm_lock  = '0;
    bp_on     = 1'b0;
    stim_lfsr = LFSR_SEED;
    chk_cnt   = 0;
    err_cnt   = 0;
    mdl_ptr   = 0;
    for (int s = 0; s < `TS_SETS; s++) begin
      for (int w = 0; w < `TS_WAYS; w++) begin
        mdl_mem[s][w] = '0;
      end
    end
    rst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Init sweep ends when the request port opens
    cycles = 0;
    @(negedge clk_i);
    while (!req_ready && cycles < INIT_TIMEOUT) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!req_ready) begin
      $display("req_ready_o never rose after the init sweep");
      err_cnt++;
    end
    @(posedge clk_i);
    #1;

    // Every set empty, each miss fills way 0
    err_before = err_cnt;
    for (int s = 0; s < `TS_SETS; s++) begin
      lookup(s, 'h10 + s, 1'b0);
    end
    finish_test("init_miss", err_before);

    // Clean hits back to back, then dirty hit and two flushes of way 0
    err_before = err_cnt;
    for (int s = 0; s < `TS_SETS; s++) begin
      lookup(s, 'h10 + s, 1'b0);
    end
    for (int s = 0; s < `TS_SETS; s++) begin
      lookup(s, 'h10 + s, 1'b1);
      flush(s, 0);
      flush(s, 0);
    end
    finish_test("hit_flush", err_before);

    // Four fills, then eight misses that evict in turn
    err_before = err_cnt;
    for (int i = 0; i < 12; i++) begin
      lookup(5, 'hA0 + i, i[0]);
    end
    finish_test("round_robin", err_before);

    // Ways 0 and 2 locked, small tag pool so hits and misses mix
    err_before = err_cnt;
    spm_lock   = 4'b0101;
    for (int i = 0; i < 80; i++) begin
      idx = rand_bits(stim_lfsr, 4);
      tg  = 'h40 + rand_bits(stim_lfsr, 3);
      d   = rand_bits(stim_lfsr, 1) != 0;
      lookup(idx, tg, d);
    end
    finish_test("partial_lock", err_before);

    // Way 0 of set 0 still empty, fill it valid and dirty
    err_before = err_cnt;
    spm_lock   = '0;
    lookup(0, 'hD0, 1'b1);
    finish_test("dirty_way0", err_before);

    // Fresh tags with every way locked, each twice since nothing is filled
    err_before = err_cnt;
    spm_lock   = '1;
    for (int s = 0; s < `TS_SETS; s += 3) begin
      lookup(s, 'hE0 + s, 1'b1);
      lookup(s, 'hE0 + s, 1'b1);
    end
    finish_test("all_locked", err_before);

    // Random lookups and flushes under random response stalls
    err_before = err_cnt;
    spm_lock   = '0;
    bp_on      = 1'b1;
    for (int i = 0; i < 300; i++) begin
      op_sel = rand_bits(stim_lfsr, 3);
      idx    = rand_bits(stim_lfsr, 4);
      if (op_sel == 0) begin
        way = rand_bits(stim_lfsr, 2);
        flush(idx, way);
      end else begin
        tg = 'h80 + rand_bits(stim_lfsr, 3);
        d  = rand_bits(stim_lfsr, 1) != 0;
        lookup(idx, tg, d);
      end
    end
    finish_test("backpressure", err_before);
    bp_on = 1'b0;

    // Failed controller properties
    err_cnt += int'(u_tag_store_top.u_ctrl.u_props.fail_cnt);
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/tag_entry_pkg.sv
hw/tag_req_pkg.sv
hw/tag_ram_bank.sv
hw/tag_compare.sv
hw/victim_select.sv
hw/tag_store_ctrl.sv
hw/resp_spill.sv
hw/tag_store_top.sv
sim/tag_store_properties.sv
sim/tag_store_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the tag store testbench with Verilator, run it, and check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tag_store_tb -f tb.f -o tag_store_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tag_store_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  exit 0
fi
exit 1
